// File: rtl/conv_macros.svh
`ifndef CONV_MACROS_SVH
`define CONV_MACROS_SVH

// Bits in one coefficient or one pixel
`define OPERAND_WIDTH 8

// Coefficient and pixel pairs in one 3x3 window
`define TAP_COUNT 9

// Input buffer depth and the credits upstream holds after reset
`define IN_DEPTH 4

// Tap buffer in front of the multipliers
`define STAGE_DEPTH 2

// Result queue depth and the credits assumed from the consumer
`define OUT_DEPTH 4

// Width of every credit counter in the design
`define CREDIT_WIDTH 3

`endif

// File: rtl/convDataPkg.sv
`include "conv_macros.svh"

package convDataPkg;

    // Signed coefficient or pixel
    typedef logic signed [`OPERAND_WIDTH-1:0] operandT;

    // Full precision product of two operands
    typedef logic signed [2*`OPERAND_WIDTH-1:0] productT;

    // Four guard bits above the product cover the nine-way sum
    typedef logic signed [2*`OPERAND_WIDTH+3:0] sumT;

    // One operand per tap
    typedef operandT [`TAP_COUNT-1:0] tapVectorT;

    // One product per tap
    typedef productT [`TAP_COUNT-1:0] productVectorT;

endpackage

// File: rtl/convFlowPkg.sv
`include "conv_macros.svh"

package convFlowPkg;

    // Credits held by the sending side of a link
    typedef logic [`CREDIT_WIDTH-1:0] creditT;

    // Slot that the next input word fills
    typedef enum logic {
        PhaseCoefficient,
        PhasePixel
    } loadPhaseT;

endpackage

// File: rtl/convStageIf.sv
`timescale 1ns/1ps

// Full window of operands from the loader to the multipliers
interface tapStageIf;
    import convDataPkg::*;

    logic      valid;
    tapVectorT coef;
    tapVectorT pixel;
    logic      credit;

    modport sender (
        output valid,
        output coef,
        output pixel,
        input  credit
    );

    modport receiver (
        input  valid,
        input  coef,
        input  pixel,
        output credit
    );
endinterface

// One dot product per window, with credit flowing back
interface sumStageIf;
    import convDataPkg::*;

    logic valid;
    sumT  sum;
    logic credit;

    modport sender (
        output valid,
        output sum,
        input  credit
    );

    modport receiver (
        input  valid,
        input  sum,
        output credit
    );
endinterface

// File: rtl/operandLoader.sv
`include "conv_macros.svh"
`timescale 1ns/1ps

module operandLoader (
    input  logic                 Clk,
    input  logic                 Rst,
    input  logic                 inValid,
    input  convDataPkg::operandT inWord,
    output logic                 inCredit,
    tapStageIf.sender            tapOut
);
    import convDataPkg::*;
    import convFlowPkg::*;

    localparam int BufPtrW = $clog2(`IN_DEPTH);
    localparam int TapPtrW = $clog2(`TAP_COUNT);

    operandT            wordBuf [`IN_DEPTH];
    logic [BufPtrW-1:0] wrPtr;
    logic [BufPtrW-1:0] rdPtr;
    logic [BufPtrW:0]   bufCount;
    loadPhaseT          phase;
    logic [TapPtrW-1:0] tapPtr;
    tapVectorT          coefSlots;
    tapVectorT          pixelSlots;
    logic               windowFull;
    creditT             stageCredits;
    logic               sendNow;
    logic               popNow;

    // A full window leaves as soon as the tap stage has room
    assign sendNow = windowFull && (stageCredits != '0);
    // Popping stalls while a full window waits for credit
    assign popNow = (bufCount != '0) && (!windowFull || sendNow);

    assign tapOut.valid = sendNow;
    assign tapOut.coef  = coefSlots;
    assign tapOut.pixel = pixelSlots;

    always_ff @(posedge Clk) begin
        if (inValid) begin
            wordBuf[wrPtr] <= inWord;
        end
        if (popNow) begin
            if (phase == PhaseCoefficient) begin
                coefSlots[tapPtr] <= wordBuf[rdPtr];
            end else begin
                pixelSlots[tapPtr] <= wordBuf[rdPtr];
            end
        end
    end

    always_ff @(posedge Clk or posedge Rst) begin
        if (Rst) begin
            wrPtr        <= '0;
            rdPtr        <= '0;
            bufCount     <= '0;
            phase        <= PhaseCoefficient;
            tapPtr       <= '0;
            windowFull   <= 1'b0;
            stageCredits <= creditT'(`STAGE_DEPTH);
            inCredit     <= 1'b0;
        end else begin
            // Freed buffer entry goes back upstream one cycle after the pop
            inCredit <= popNow;

            if (inValid) begin
                wrPtr <= (wrPtr == BufPtrW'(`IN_DEPTH - 1)) ? '0 : wrPtr + 1'b1;
            end
            case ({inValid, popNow})
                2'b10:   bufCount <= bufCount + 1'b1;
                2'b01:   bufCount <= bufCount - 1'b1;
                default: ;
            endcase

            if (sendNow) begin
                windowFull <= 1'b0;
            end
            if (popNow) begin
                rdPtr <= (rdPtr == BufPtrW'(`IN_DEPTH - 1)) ? '0 : rdPtr + 1'b1;
                phase <= (phase == PhaseCoefficient) ? PhasePixel : PhaseCoefficient;
                // Tap advances once its pixel has landed
                if (phase == PhasePixel) begin
                    if (tapPtr == TapPtrW'(`TAP_COUNT - 1)) begin
                        tapPtr     <= '0;
                        windowFull <= 1'b1;
                    end else begin
                        tapPtr <= tapPtr + 1'b1;
                    end
                end
            end

            case ({sendNow, tapOut.credit})
                2'b10:   stageCredits <= stageCredits - 1'b1;
                2'b01:   stageCredits <= stageCredits + 1'b1;
                default: ;
            endcase
        end
    end

endmodule

// File: rtl/multiplierBank.sv
`include "conv_macros.svh"
`timescale 1ns/1ps

module multiplierBank (
    input  logic                       Clk,
    input  logic                       Rst,
    tapStageIf.receiver                tapIn,
    sumStageIf.sender                  queueCredit,
    output logic                       prodValid,
    output convDataPkg::productVectorT products
);
    import convDataPkg::*;
    import convFlowPkg::*;

    localparam int PtrW = $clog2(`STAGE_DEPTH);

    tapVectorT       coefBuf  [`STAGE_DEPTH];
    tapVectorT       pixelBuf [`STAGE_DEPTH];
    logic [PtrW-1:0] wrPtr;
    logic [PtrW-1:0] rdPtr;
    logic [PtrW:0]   entryCount;
    creditT          queueCredits;
    logic            launch;
    logic            stageFreed;

    // A window starts only with a free result queue slot reserved
    assign launch = (entryCount != '0) && (queueCredits != '0);

    assign tapIn.credit = stageFreed;

    always_ff @(posedge Clk) begin
        if (tapIn.valid) begin
            coefBuf[wrPtr]  <= tapIn.coef;
            pixelBuf[wrPtr] <= tapIn.pixel;
        end
        if (launch) begin
            for (int i = 0; i < `TAP_COUNT; i++) begin
                products[i] <= $signed(coefBuf[rdPtr][i]) * $signed(pixelBuf[rdPtr][i]);
            end
        end
    end

    always_ff @(posedge Clk or posedge Rst) begin
        if (Rst) begin
            wrPtr        <= '0;
            rdPtr        <= '0;
            entryCount   <= '0;
            queueCredits <= creditT'(`OUT_DEPTH);
            prodValid    <= 1'b0;
            stageFreed   <= 1'b0;
        end else begin
            // Products and the tap stage credit appear together
            prodValid  <= launch;
            stageFreed <= launch;

            if (tapIn.valid) begin
                wrPtr <= (wrPtr == PtrW'(`STAGE_DEPTH - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (launch) begin
                rdPtr <= (rdPtr == PtrW'(`STAGE_DEPTH - 1)) ? '0 : rdPtr + 1'b1;
            end
            case ({tapIn.valid, launch})
                2'b10:   entryCount <= entryCount + 1'b1;
                2'b01:   entryCount <= entryCount - 1'b1;
                default: ;
            endcase

            case ({launch, queueCredit.credit})
                2'b10:   queueCredits <= queueCredits - 1'b1;
                2'b01:   queueCredits <= queueCredits + 1'b1;
                default: ;
            endcase
        end
    end

endmodule

// File: rtl/adderTree.sv
`include "conv_macros.svh"
`timescale 1ns/1ps

module adderTree (
    input  logic                       Clk,
    input  logic                       Rst,
    input  logic                       prodValid,
    input  convDataPkg::productVectorT products,
    sumStageIf.sender                  sumOut
);
    import convDataPkg::*;

    // Taps reduced three at a time in the first stage
    localparam int GroupSize  = 3;
    localparam int GroupCount = `TAP_COUNT / GroupSize;

    sumT  partialSums [GroupCount];
    logic partialValid;
    sumT  groupTotal;
    sumT  sumReg;
    logic sumValid;

    assign sumOut.valid = sumValid;
    assign sumOut.sum   = sumReg;

    // Second stage input
    always_comb begin
        groupTotal = '0;
        for (int g = 0; g < GroupCount; g++) begin
            groupTotal = groupTotal + partialSums[g];
        end
    end

    always_ff @(posedge Clk) begin
        for (int g = 0; g < GroupCount; g++) begin
            partialSums[g] <= sumT'(products[GroupSize*g])
                            + sumT'(products[GroupSize*g + 1])
                            + sumT'(products[GroupSize*g + 2]);
        end
        sumReg <= groupTotal;
    end

    // Valid bit follows the data through both stages
    always_ff @(posedge Clk or posedge Rst) begin
        if (Rst) begin
            partialValid <= 1'b0;
            sumValid     <= 1'b0;
        end else begin
            partialValid <= prodValid;
            sumValid     <= partialValid;
        end
    end

endmodule

// File: rtl/resultQueue.sv
`include "conv_macros.svh"
`timescale 1ns/1ps

module resultQueue (
    input  logic             Clk,
    input  logic             Rst,
    sumStageIf.receiver      sumIn,
    sumStageIf.receiver      freedSlot,
    output logic             outValid,
    output convDataPkg::sumT outSum,
    input  logic             outCredit
);
    import convDataPkg::*;
    import convFlowPkg::*;

    localparam int PtrW = $clog2(`OUT_DEPTH);

    sumT             queueMem [`OUT_DEPTH];
    logic [PtrW-1:0] wrPtr;
    logic [PtrW-1:0] rdPtr;
    logic [PtrW:0]   entryCount;
    creditT          outCredits;
    logic            sendNow;
    logic            slotFreed;

    // Oldest entry leaves whenever the consumer has room for it
    assign sendNow  = (entryCount != '0) && (outCredits != '0);
    assign outValid = sendNow;
    assign outSum   = queueMem[rdPtr];

    // Each slot sent downstream returns a credit to the multiplier bank
    assign freedSlot.credit = slotFreed;

    always_ff @(posedge Clk) begin
        if (sumIn.valid) begin
            queueMem[wrPtr] <= sumIn.sum;
        end
    end

    always_ff @(posedge Clk or posedge Rst) begin
        if (Rst) begin
            wrPtr      <= '0;
            rdPtr      <= '0;
            entryCount <= '0;
            outCredits <= creditT'(`OUT_DEPTH);
            slotFreed  <= 1'b0;
        end else begin
            slotFreed <= sendNow;
            if (sumIn.valid) begin
                wrPtr <= (wrPtr == PtrW'(`OUT_DEPTH - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (sendNow) begin
                rdPtr <= (rdPtr == PtrW'(`OUT_DEPTH - 1)) ? '0 : rdPtr + 1'b1;
            end
            case ({sumIn.valid, sendNow})
                2'b10:   entryCount <= entryCount + 1'b1;
                2'b01:   entryCount <= entryCount - 1'b1;
                default: ;
            endcase
            case ({sendNow, outCredit})
                2'b10:   outCredits <= outCredits - 1'b1;
                2'b01:   outCredits <= outCredits + 1'b1;
                default: ;
            endcase
        end
    end

endmodule

// File: rtl/convTop.sv
`timescale 1ns/1ps

module convTop (
    input  logic                 Clk,
    input  logic                 Rst,
    input  logic                 inValid,
    input  convDataPkg::operandT inWord,
    output logic                 inCredit,
    output logic                 outValid,
    output convDataPkg::sumT     outSum,
    input  logic                 outCredit
);
    import convDataPkg::*;

    tapStageIf tapLink ();
    sumStageIf sumLink ();
    // Return path for result queue slots
    sumStageIf freeLink ();

    logic          prodValid;
    productVectorT products;

    operandLoader i_loader (
        .Clk      (Clk),
        .Rst      (Rst),
        .inValid  (inValid),
        .inWord   (inWord),
        .inCredit (inCredit),
        .tapOut   (tapLink)
    );

    multiplierBank i_multipliers (
        .Clk         (Clk),
        .Rst         (Rst),
        .tapIn       (tapLink),
        .queueCredit (freeLink),
        .prodValid   (prodValid),
        .products    (products)
    );

    adderTree i_adders (
        .Clk       (Clk),
        .Rst       (Rst),
        .prodValid (prodValid),
        .products  (products),
        .sumOut    (sumLink)
    );

    resultQueue i_results (
        .Clk       (Clk),
        .Rst       (Rst),
        .sumIn     (sumLink),
        .freedSlot (freeLink),
        .outValid  (outValid),
        .outSum    (outSum),
        .outCredit (outCredit)
    );

endmodule

// File: tests/convTb.sv
`include "conv_macros.svh"
`timescale 1ns/1ps

module convTb;
    import convDataPkg::*;

    localparam int          WindowCount = 200;
    localparam int          ClkPeriod   = 20;
    localparam int          InputDelay  = 1;
    localparam int unsigned Seed        = 32'hf06d3f96;
    // Long output stall, and its tail in which the input side must be quiet
    localparam int          StallCycles = 600;
    localparam int          QuietCycles = 200;

    logic    Clk = 1'b0;
    logic    Rst;
    logic    inValid;
    operandT inWord;
    logic    inCredit;
    logic    outValid;
    sumT     outSum;
    logic    outCredit;

    int expectedSums [$];
    int producerCredits = `IN_DEPTH;
    int heldCredits     = `OUT_DEPTH;
    int creditsOwed     = 0;
    int wordsSent       = 0;
    int creditsSeen     = 0;
    int sumsSeen        = 0;
    int stallLeft       = 0;
    bit stallDone       = 1'b0;
    bit resetDone       = 1'b0;

    convTop i_dut (
        .Clk       (Clk),
        .Rst       (Rst),
        .inValid   (inValid),
        .inWord    (inWord),
        .inCredit  (inCredit),
        .outValid  (outValid),
        .outSum    (outSum),
        .outCredit (outCredit)
    );

    always #(ClkPeriod / 2) Clk = ~Clk;

    task automatic checkValue(input longint actual, input longint expected, input string what);
        if (actual !== expected) begin
            $display("** Error at %0t ns: %s, got %0d, expected %0d",
                     $time, what, actual, expected);
            $display("Regression failed");
            $fatal(1, "Check failed: %s", what);
        end
    endtask

    function automatic operandT pickOperand(input int windowIndex, input bit isPixel);
        int unsigned roll;
        roll = $urandom_range(0, 7);
        // First two windows pin the largest products
        if (windowIndex == 0) begin
            return operandT'(-128);
        end
        if (windowIndex == 1) begin
            return isPixel ? operandT'(127) : operandT'(-128);
        end
        if (roll == 0) begin
            return operandT'(-128);
        end
        if (roll == 1) begin
            return operandT'(127);
        end
        return operandT'($urandom_range(0, 255));
    endfunction

    // Reset and end of run checks
    initial begin : supervisor
        void'($urandom(Seed));
        Rst = 1'b1;
        repeat (10) @(posedge Clk);
        #InputDelay;
        Rst = 1'b0;
        resetDone = 1'b1;
        wait (sumsSeen == WindowCount);
        // Let the last input credits drain back
        repeat (20) @(posedge Clk);
        checkValue(creditsSeen, wordsSent, "inCredit pulses against words sent");
        checkValue(producerCredits, `IN_DEPTH, "input credits after the run");
        $display("Regression passed");
        $finish;
    end

    initial begin : producer
        operandT words [$];
        operandT coef;
        operandT pixel;
        int      total;
        inValid = 1'b0;
        inWord  = '0;
        wait (resetDone);
        // Idle stretch with outputs expected quiet
        repeat (5) @(posedge Clk);
        for (int w = 0; w < WindowCount; w++) begin
            total = 0;
            for (int t = 0; t < `TAP_COUNT; t++) begin
                coef  = pickOperand(w, 1'b0);
                pixel = pickOperand(w, 1'b1);
                words.push_back(coef);
                words.push_back(pixel);
                total += int'(coef) * int'(pixel);
            end
            expectedSums.push_back(total);
            while (words.size() > 0) begin
                @(posedge Clk);
                #InputDelay;
                inValid = 1'b0;
                if (producerCredits > 0 && $urandom_range(0, 3) != 0) begin
                    inValid = 1'b1;
                    inWord  = words.pop_front();
                    producerCredits--;
                    wordsSent++;
                end
            end
        end
        @(posedge Clk);
        #InputDelay;
        inValid = 1'b0;
    end

    initial begin : consumer
        outCredit = 1'b0;
        wait (resetDone);
        forever begin
            @(posedge Clk);
            #InputDelay;
            outCredit = 1'b0;
            // One long stall halfway through the run
            if (!stallDone && sumsSeen >= WindowCount / 2) begin
                stallDone = 1'b1;
                stallLeft = StallCycles;
            end
            if (stallLeft > 0) begin
                stallLeft--;
            end else if (creditsOwed > 0 && $urandom_range(0, 2) != 0) begin
                outCredit = 1'b1;
                creditsOwed--;
            end
        end
    end

    // Outputs sampled mid cycle away from the edges
    always @(negedge Clk) begin
        if (inCredit) begin
            checkValue(creditsSeen < wordsSent, 1, "inCredit without an accepted word");
            creditsSeen++;
            producerCredits++;
            checkValue(producerCredits <= `IN_DEPTH, 1, "producer credit above buffer depth");
        end
        if (stallLeft > 0 && stallLeft <= QuietCycles) begin
            checkValue(inCredit, 0, "inCredit still pulsing late in the output stall");
        end
        if (outValid) begin
            checkValue(heldCredits > 0, 1, "outValid with zero consumer credit");
            checkValue(expectedSums.size() > 0, 1, "outValid with no window pending");
            checkValue(longint'(outSum), expectedSums.pop_front(),
                       $sformatf("sum of window %0d", sumsSeen));
            sumsSeen++;
            creditsOwed++;
        end
        heldCredits = heldCredits - int'(outValid) + int'(outCredit);
    end

    initial begin : watchdog
        #((WindowCount * 400 + 1000) * ClkPeriod);
        $display("Timeout: only %0d of %0d sums arrived", sumsSeen, WindowCount);
        $display("Regression failed");
        $fatal(1, "Simulation timed out");
    end

endmodule

// File: project.f
+incdir+rtl
rtl/convDataPkg.sv
rtl/convFlowPkg.sv
rtl/convStageIf.sv
rtl/operandLoader.sv
rtl/multiplierBank.sv
rtl/adderTree.sv
rtl/resultQueue.sv
rtl/convTop.sv
tests/convTb.sv

// File: Makefile
# Verilator build and run for the 3x3 convolution engine

VERILATOR ?= verilator
TOP       ?= convTb
BUILD_DIR ?= build
SEED      ?= 1
FILE_LIST ?= project.f
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -Wno-fatal

SIM     := $(BUILD_DIR)/V$(TOP)
SOURCES := $(wildcard rtl/*.sv rtl/*.svh tests/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILE_LIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

# Any $$fatal in the testbench gives a nonzero exit status here
run: compile
	$(SIM) +verilator+seed+$(SEED)

clean:
	rm -rf $(BUILD_DIR)
